// ==== filelist.f ====
+incdir+tb
src/noc_link_pkg.sv
src/sync_transmitter.sv
src/sync_receiver.sv
src/flit_classifier.sv
src/noc_link_top.sv
tb/noc_link_tb.sv

// ==== src/flit_classifier.sv ====
`timescale 1ns/1ps

module flit_classifier
   import noc_link_pkg::*;
(
   input  logic                   clock,
   input  logic                   reset,       // active low, synchronous
   input  logic                   rx_valid,
   input  flit_t                  rx_flit,
   output logic                   out_valid,   // rx_valid delayed one cycle
   output class_result_t          out_result,
   output logic [count_width-1:0] pkt_count    // clean packets closed
);

   payload_u   pl;
   logic       head_kind;   // head or single
   logic       last_kind;   // tail or single
   logic       in_pkt;      // between a head and its tail
   logic       err;
   logic [7:0] dest_q;      // dest of the open packet

   assign pl        = rx_flit.payload;
   assign head_kind = (rx_flit.kind == ft_head) || (rx_flit.kind == ft_single);
   assign last_kind = (rx_flit.kind == ft_tail) || (rx_flit.kind == ft_single);

   // head only legal outside a packet, body/tail only inside
   assign err = (in_pkt == head_kind);

   always_ff @(posedge clock) begin
      if (!reset) begin
         out_valid <= 1'b0;
         in_pkt    <= 1'b0;
         dest_q    <= '0;
         pkt_count <= '0;
      end else begin
         out_valid <= rx_valid;
         if (rx_valid) begin
            if (head_kind)
               dest_q <= pl.head.dest;   // routing view of the word
            // framing, a stray head restarts the packet
            if (last_kind)
               in_pkt <= 1'b0;
            else if (head_kind)
               in_pkt <= 1'b1;
            if (last_kind && !err)
               pkt_count <= pkt_count + 1'b1;
         end
      end
   end

   // result register, payload only
   always_ff @(posedge clock) begin
      if (rx_valid) begin
         out_result.dest      <= head_kind ? pl.head.dest : dest_q;
         out_result.data      <= pl.raw;   // plain data view
         out_result.is_head   <= head_kind;
         out_result.is_last   <= last_kind;
         out_result.frame_err <= err;
      end
   end

endmodule

// ==== src/noc_link_pkg.sv ====
package noc_link_pkg;

   // link geometry
   localparam int flit_width    = 34;
   localparam int payload_width = 32;
   localparam int count_width   = 16;   // finished packet counter

   // flit type codes, carried in the top two bits of a flit
   localparam logic [1:0] ft_body   = 2'b00;
   localparam logic [1:0] ft_head   = 2'b01;   // opens a packet
   localparam logic [1:0] ft_tail   = 2'b10;   // closes a packet
   localparam logic [1:0] ft_single = 2'b11;   // head and tail in one

   // transmitter two-phase states
   localparam logic [1:0] tx_send_hi = 2'b00;  // idle, next req edge is rising
   localparam logic [1:0] tx_wait_hi = 2'b01;  // req high, waiting for ack high
   localparam logic [1:0] tx_send_lo = 2'b10;  // idle, next req edge is falling
   localparam logic [1:0] tx_wait_lo = 2'b11;  // req low, waiting for ack low

   // routing view of a head payload
   typedef struct packed {
      logic [7:0]                  dest;
      logic [7:0]                  src;
      logic [7:0]                  len;   // flits in packet
      logic [payload_width-25:0]   rsvd;
   } head_fields_t;

   // same word, head fields or plain data depending on flit kind
   typedef union packed {
      head_fields_t              head;
      logic [payload_width-1:0]  raw;
   } payload_u;

   typedef struct packed {
      logic [flit_width-payload_width-1:0] kind;   // ft_* code
      payload_u                            payload;
   } flit_t;

   // one decoded flit as seen by the consumer
   typedef struct packed {
      logic [7:0]                dest;    // from head, held for body/tail
      logic [payload_width-1:0]  data;    // raw payload word
      logic                      is_head;
      logic                      is_last;
      logic                      frame_err;
   } class_result_t;

endpackage

// ==== src/noc_link_top.sv ====
`timescale 1ns/1ps

module noc_link_top
   import noc_link_pkg::*;
(
   input  logic                   clock,
   input  logic                   reset,       // active low, synchronous
   input  logic                   valid_in,    // active low strobe
   input  flit_t                  flit_in,
   input  logic                   chnl_stop,   // sender side back-pressure
   input  logic                   hold,        // receiver side back-pressure
   output logic                   stop_in,
   output logic                   out_valid,
   output class_result_t          out_result,
   output logic [count_width-1:0] pkt_count
);

   // link between the two ends
   logic  req;
   logic  ack;
   flit_t link_flit;

   // receiver to classifier
   logic  rx_valid;
   flit_t rx_flit;

   sync_transmitter tx0 (
      .clock     (clock),
      .reset     (reset),
      .valid_in  (valid_in),
      .flit_in   (flit_in),
      .chnl_stop (chnl_stop),
      .ack       (ack),
      .req       (req),
      .link_flit (link_flit),
      .stop_in   (stop_in)
   );

   sync_receiver rx0 (
      .clock     (clock),
      .reset     (reset),
      .req       (req),
      .link_flit (link_flit),
      .hold      (hold),
      .ack       (ack),
      .rx_valid  (rx_valid),
      .rx_flit   (rx_flit)
   );

   flit_classifier cls0 (
      .clock      (clock),
      .reset      (reset),
      .rx_valid   (rx_valid),
      .rx_flit    (rx_flit),
      .out_valid  (out_valid),
      .out_result (out_result),
      .pkt_count  (pkt_count)
   );

endmodule

// ==== src/sync_receiver.sv ====
`timescale 1ns/1ps

module sync_receiver
   import noc_link_pkg::*;
(
   input  logic  clock,
   input  logic  reset,       // active low, synchronous
   input  logic  req,         // toggle from transmitter
   input  flit_t link_flit,   // stable while req is unanswered
   input  logic  hold,        // delays capture and ack
   output logic  ack,
   output logic  rx_valid,    // one-cycle pulse per flit
   output flit_t rx_flit
);

   logic req1, req2;   // two-stage req synchroniser
   logic req_seen;     // last req level acted upon
   logic pending;      // toggle seen, not yet taken
   logic accept;

   // a toggle stays pending until taken, so hold can last any length
   assign pending = req2 ^ req_seen;
   assign accept  = pending & ~hold;

   always_ff @(posedge clock) begin
      if (!reset) begin
         req1     <= 1'b0;
         req2     <= 1'b0;
         req_seen <= 1'b0;
         ack      <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         req1     <= req;
         req2     <= req1;
         rx_valid <= accept;          // pulse on the capture edge
         if (accept) begin
            req_seen <= req2;         // toggle consumed
            ack      <= ~ack;         // answer with our own toggle
         end
      end
   end

   // capture register
   // transmitter keeps link_flit frozen until this ack comes back
   always_ff @(posedge clock) begin
      if (accept)
         rx_flit <= link_flit;
   end

endmodule

// ==== src/sync_transmitter.sv ====
`timescale 1ns/1ps

module sync_transmitter
   import noc_link_pkg::*;
(
   input  logic  clock,
   input  logic  reset,       // active low, synchronous
   input  logic  valid_in,    // active low strobe
   input  flit_t flit_in,
   input  logic  chnl_stop,   // freezes everything while high
   input  logic  ack,         // toggle from receiver
   output logic  req,         // toggles once per flit
   output flit_t link_flit,
   output logic  stop_in
);

   logic [1:0] fsm_state;
   logic       ack1, ack2, ack3;   // ack synchroniser chain
   logic       waiting;
   logic       matched;
   logic       busy;

   // ack has caught up with req once it clears the third stage
   assign matched = (ack3 == req);
   assign waiting = (fsm_state == tx_wait_hi) || (fsm_state == tx_wait_lo);

   // busy only while a flit is in flight and unanswered
   assign busy    = waiting && !matched;
   assign stop_in = busy | chnl_stop;

   always_ff @(posedge clock) begin
      if (!reset) begin
         fsm_state <= tx_send_hi;
         req       <= 1'b0;
         ack1      <= 1'b0;
         ack2      <= 1'b0;
         ack3      <= 1'b0;
      end else if (!chnl_stop) begin   // channel stop holds all state
         ack1 <= ack;
         ack2 <= ack1;
         ack3 <= ack2;

         case (fsm_state)
            tx_send_hi: begin
               if (!valid_in) begin
                  req       <= 1'b1;         // rising req edge
                  fsm_state <= tx_wait_hi;
               end
            end
            tx_wait_hi: begin
               if (matched) begin
                  // back-to-back flit may be taken on the release edge
                  if (!valid_in) begin
                     req       <= 1'b0;
                     fsm_state <= tx_wait_lo;
                  end else begin
                     fsm_state <= tx_send_lo;
                  end
               end
            end
            tx_send_lo: begin
               if (!valid_in) begin
                  req       <= 1'b0;         // falling req edge
                  fsm_state <= tx_wait_lo;
               end
            end
            tx_wait_lo: begin
               if (matched) begin
                  if (!valid_in) begin
                     req       <= 1'b1;
                     fsm_state <= tx_wait_hi;
                  end else begin
                     fsm_state <= tx_send_hi;
                  end
               end
            end
            default: begin
               fsm_state <= tx_send_hi;
               req       <= 1'b0;
            end
         endcase
      end
   end

   // data register, open whenever a new flit may be offered
   // locked from the req toggle until the ack returns, and under chnl_stop
   always_ff @(posedge clock) begin
      if (!stop_in)
         link_flit <= flit_in;
   end

endmodule

// ==== tb/noc_link_vectors.svh ====
// columns: test name, flit kind, payload, chnl_stop cycles, hold cycles,
//          expected frame_err, expected pkt_count after the flit
// head payload is dest, src, len, reserved from the top byte down
add_vec("single_a",     ft_single, 32'h2A13_0100, 0, 0, 1'b0, 1);   // one-flit packet
add_vec("pkt_head",     ft_head,   32'h5C2A_0400, 0, 0, 1'b0, 1);
add_vec("pkt_body0",    ft_body,   32'hDEAD_BEEF, 0, 0, 1'b0, 1);   // dest 5c carried
add_vec("pkt_body1",    ft_body,   32'h0123_4567, 0, 0, 1'b0, 1);
add_vec("pkt_tail",     ft_tail,   32'h89AB_CDEF, 0, 0, 1'b0, 2);   // closes packet
add_vec("stray_body",   ft_body,   32'hBADB_0D1E, 0, 0, 1'b1, 2);   // outside any packet
add_vec("open_head",    ft_head,   32'h7700_0300, 0, 0, 1'b0, 2);
add_vec("nested_head",  ft_head,   32'h6611_0200, 0, 0, 1'b1, 2);   // head inside packet
add_vec("nested_tail",  ft_tail,   32'h0F0F_0F0F, 0, 0, 1'b0, 3);   // packet still open
add_vec("stray_tail",   ft_tail,   32'h1234_5678, 0, 0, 1'b1, 3);
// back-pressure on either end
add_vec("stop_single",  ft_single, 32'h4455_0100, 6, 0, 1'b0, 4);   // chnl_stop only
add_vec("hold_single",  ft_single, 32'h3322_0100, 0, 7, 1'b0, 5);   // hold only
add_vec("stall_head",   ft_head,   32'h1100_0200, 3, 5, 1'b0, 5);   // hold outlasts stop
add_vec("stall_tail",   ft_tail,   32'hCAFE_F00D, 4, 2, 1'b0, 6);   // stop outlasts hold

// ==== tb/noc_link_tb.sv ====
`timescale 1ns/1ps

module noc_link_tb
   import noc_link_pkg::*;
();

   localparam int idle_timeout    = 100;   // cycles for stop_in to fall
   localparam int deliver_timeout = 100;   // cycles for out_valid
   localparam int clean_latency   = 4;     // sampling edge to out_valid edge
   localparam int random_packets  = 20;

   // one table row
   typedef struct packed {
      logic [1:0]             kind;
      logic [31:0]            payload;
      logic [7:0]             stop_len;   // chnl_stop cycles after the strobe
      logic [7:0]             hold_len;   // hold cycles from the strobe
      logic                   exp_err;
      logic [count_width-1:0] exp_cnt;    // pkt_count once this flit is out
   } vec_t;

   logic                   clock;
   logic                   reset;
   logic                   valid_in;
   flit_t                  flit_in;
   logic                   chnl_stop;
   logic                   hold;
   logic                   stop_in;
   logic                   out_valid;
   class_result_t          out_result;
   logic [count_width-1:0] pkt_count;

   vec_t          vec_q[$];
   string         name_q[$];
   class_result_t res_q[$];           // results in arrival order
   int            edge_q[$];          // posedge number that raised out_valid
   int            cycle_cnt = 0;
   int            out_count = 0;
   int            err_count = 0;
   int            tests_run = 0;
   int            tests_failed = 0;
   int            model_cnt = 0;
   logic [7:0]    model_dest = '0;    // dest of the open packet
   logic [31:0]   rng_state = 32'd93;
   bit            aborted = 0;

   noc_link_top dut0 (
      .clock      (clock),
      .reset      (reset),
      .valid_in   (valid_in),
      .flit_in    (flit_in),
      .chnl_stop  (chnl_stop),
      .hold       (hold),
      .stop_in    (stop_in),
      .out_valid  (out_valid),
      .out_result (out_result),
      .pkt_count  (pkt_count)
   );

   always #5 clock = ~clock;   // 10 ns period

   always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

   // output monitor, catches every pulse including doubles
   always @(negedge clock) begin
      if (reset && out_valid) begin
         res_q.push_back(out_result);
         edge_q.push_back(cycle_cnt);
         out_count <= out_count + 1;   // seen by the main loop one negedge on
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   task automatic check_value(input string test, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %0h, actual %0h", test, what, exp, act);
         err_count++;
      end
   endtask

   task automatic abandon_run(input string why);
      $display("ERROR: %s", why);
      err_count++;
      aborted = 1;   // remaining tests are skipped
   endtask

   task automatic add_vec(input string name, input logic [1:0] kind, input logic [31:0] payload,
                          input int stop_len, input int hold_len, input logic exp_err,
                          input int exp_cnt);
      vec_t v;
      v.kind     = kind;
      v.payload  = payload;
      v.stop_len = stop_len;
      v.hold_len = hold_len;
      v.exp_err  = exp_err;
      v.exp_cnt  = exp_cnt;
      vec_q.push_back(v);
      name_q.push_back(name);
   endtask

   task automatic load_table();
      `include "noc_link_vectors.svh"
   endtask

   task automatic wait_idle(input string test, output bit ok);
      int n;
      n = 0;
      while (stop_in && n < idle_timeout) begin
         @(negedge clock);
         n++;
      end
      ok = !stop_in;
      if (!ok)
         abandon_run({"stop_in stuck high before ", test});
   endtask

   // one flit through the link, with optional stalls on either end
   task automatic run_test(input string test, input vec_t v);
      class_result_t exp_res;
      class_result_t got;
      int            idx;
      int            t0;
      int            stall;
      int            n;
      int            i;
      int            errs_before;
      bit            ok;
      if (!aborted) begin
         errs_before = err_count;
         idx         = tests_run;
         wait_idle(test, ok);
         if (ok) begin
            check_value(test, "flits delivered", idx, out_count);   // none lost or doubled
            if (v.kind == ft_head || v.kind == ft_single)
               model_dest = v.payload[31:24];   // dest is the top head byte
            exp_res.dest      = model_dest;
            exp_res.data      = v.payload;
            exp_res.is_head   = (v.kind == ft_head) || (v.kind == ft_single);
            exp_res.is_last   = (v.kind == ft_tail) || (v.kind == ft_single);
            exp_res.frame_err = v.exp_err;
            flit_in  = {v.kind, v.payload};
            valid_in = 1'b0;                 // strobe
            hold     = (v.hold_len != 0);
            t0       = cycle_cnt + 1;        // edge that samples the strobe
            @(negedge clock);
            valid_in  = 1'b1;
            flit_in   = {ft_body, next_rand()};   // junk, register must stay locked
            chnl_stop = (v.stop_len != 0);
            stall     = (v.stop_len > v.hold_len) ? v.stop_len : v.hold_len;
            for (i = 1; i <= stall; i++) begin
               @(negedge clock);
               check_value(test, "stop_in in stall", 1, stop_in);
               if (hold)
                  check_value(test, "out_valid in hold", 0, out_valid);
               if (i >= v.stop_len)
                  chnl_stop = 1'b0;
               if (i >= v.hold_len)
                  hold = 1'b0;
            end
            n = 0;
            while (out_count <= idx && n < deliver_timeout) begin
               @(negedge clock);
               n++;
            end
            if (out_count <= idx) begin
               abandon_run({"flit never came out for ", test});
            end else begin
               got = res_q[idx];
               check_value(test, "dest", exp_res.dest, got.dest);
               check_value(test, "data", exp_res.data, got.data);
               check_value(test, "is_head", exp_res.is_head, got.is_head);
               check_value(test, "is_last", exp_res.is_last, got.is_last);
               check_value(test, "frame_err", exp_res.frame_err, got.frame_err);
               check_value(test, "pkt_count", v.exp_cnt, pkt_count);
               if (stall == 0)
                  check_value(test, "latency", clean_latency, edge_q[idx] - t0);
            end
         end
         model_cnt = v.exp_cnt;
         tests_run++;
         if (err_count == errs_before) begin
            $display("test %s: ok", test);
         end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test, err_count - errs_before);
         end
      end
   endtask

   // head, 0 to 2 bodies, tail
   task automatic run_random_packets();
      vec_t v;
      int   p;
      int   b;
      int   body_n;
      for (p = 0; p < random_packets; p++) begin
         body_n    = (next_rand() >> 16) % 3;
         v         = '0;   // no stalls, no framing error
         v.kind    = ft_head;
         v.payload = next_rand();
         v.exp_cnt = model_cnt;
         run_test($sformatf("rnd%0d_head", p), v);
         for (b = 0; b < body_n; b++) begin
            v.kind    = ft_body;
            v.payload = next_rand();
            v.exp_cnt = model_cnt;
            run_test($sformatf("rnd%0d_body%0d", p, b), v);
         end
         v.kind    = ft_tail;
         v.payload = next_rand();
         v.exp_cnt = model_cnt + 1;   // tail closes a clean packet
         run_test($sformatf("rnd%0d_tail", p), v);
      end
   endtask

   initial begin
      int k;
      int base_cnt;
      bit ok;
      clock     = 1'b0;
      reset     = 1'b0;
      valid_in  = 1'b1;   // strobe is active low
      flit_in   = '0;
      chnl_stop = 1'b0;
      hold      = 1'b0;
      load_table();
      repeat (5) @(negedge clock);
      reset = 1'b1;
      @(negedge clock);
      check_value("reset", "stop_in", 0, stop_in);
      check_value("reset", "out_valid", 0, out_valid);
      check_value("reset", "pkt_count", 0, pkt_count);
      for (k = 0; k < vec_q.size(); k++)
         run_test(name_q[k], vec_q[k]);
      base_cnt = model_cnt;
      run_random_packets();
      if (!aborted) begin
         wait_idle("end of run", ok);
         if (ok) begin
            check_value("end_of_run", "flits delivered", tests_run, out_count);
            check_value("end_of_run", "pkt_count", base_cnt + random_packets, pkt_count);
         end
      end
      $display("tests: %0d  failed: %0d  mismatches: %0d", tests_run, tests_failed, err_count);
      if (err_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
